//--- testbench/csr_patterns.txt
// acc_addr_op_wdata_trap_cause_pcif_pcid_events_chk_exprdata_expirq, one row per cycle
// trap: 8 save_cause 4 save_if 2 save_id 1 mret; events bit 1 mem_load; op 1 wr 2 set 3 clr
0_300_0_00000000_0_00_00000000_00000000_000_1_00001800_0
0_7a1_0_00000000_0_00_00000000_00000000_000_1_00000003_0
1_7a0_1_00000011_0_00_00000000_00000000_000_1_00000000_0
1_341_1_00001000_0_00_00000000_00000000_002_1_00000000_0
1_341_2_00000034_0_00_00000000_00000000_000_1_00001000_0
1_341_3_00001000_0_00_00000000_00000000_002_1_00001034_0
1_341_0_ffffffff_0_00_00000000_00000000_000_1_00000034_0
0_341_1_dead0000_0_00_00000000_00000000_000_1_00000034_0
0_341_0_00000000_0_00_00000000_00000000_000_1_00000034_0
1_300_2_00000008_0_00_00000000_00000000_000_1_00001800_0
0_300_0_00000000_c_2b_00000200_00000300_000_1_00001808_1
0_341_0_00000000_0_00_00000000_00000000_000_1_00000200_0
0_342_0_00000000_1_00_00000000_00000000_000_1_8000000b_0
0_300_0_00000000_0_00_00000000_00000000_000_1_00001888_1
0_f14_0_00000000_0_00_00000000_00000000_000_1_00000545_1
0_305_0_00000000_0_00_00000000_00000000_002_1_1c000001_1
0_784_0_00000000_0_00_00000000_00000000_000_1_00000002_1
0_784_0_00000000_0_00_00000000_00000000_000_1_00000003_1
1_7a1_3_00000001_0_00_00000000_00000000_000_1_00000003_1
0_780_0_00000000_0_00_00000000_00000000_000_1_0000000f_1
0_780_0_00000000_0_00_00000000_00000000_000_1_00000010_1
0_780_0_00000000_0_00_00000000_00000000_000_1_00000010_1
1_79f_1_ffffffff_0_00_00000000_00000000_000_1_00000000_1
0_785_0_00000000_0_00_00000000_00000000_000_1_ffffffff_1
1_7a1_2_00000001_0_00_00000000_00000000_000_1_00000002_1
0_780_0_00000000_0_00_00000000_00000000_000_0_00000000_1
1_7a1_3_00000002_0_00_00000000_00000000_000_1_00000003_1
0_780_0_00000000_0_00_00000000_00000000_000_1_ffffffff_1
0_780_0_00000000_0_00_00000000_00000000_000_1_00000000_1
0_780_0_00000000_0_00_00000000_00000000_000_1_00000001_1

//--- src.f
design/csr_pkg.sv
design/csr_access_decode.sv
design/trap_csr_regs.sv
design/perf_cfg_regs.sv
design/perf_counter_bank.sv
design/csr_file_top.sv
testbench/tb_csr_file.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_csr_file
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- testbench/tb_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_file;

  import csr_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int NUM_PATTERNS = 30;
  localparam int PAT_W        = 180;
  // reset, one idle cycle and some slack on top of the replay
  localparam int WATCHDOG_NS  = (NUM_PATTERNS + 8) * CLK_PERIOD + 40;

  logic          clk;
  logic          rst_n;
  hart_core_t    core_id;
  hart_cluster_t cluster_id;
  tvec_base_t    boot_addr;
  logic          csr_access;
  csr_addr_t     csr_addr;
  csr_op_e       csr_op;
  csr_data_t     csr_wdata;
  csr_data_t     pc_if;
  csr_data_t     pc_id;
  logic          csr_save_if;
  logic          csr_save_id;
  logic          csr_save_cause;
  logic          csr_restore_mret;
  cause_t        csr_cause;
  logic          id_valid;
  logic          is_decoding;
  logic          is_compressed;
  logic          ld_stall;
  logic          imiss;
  logic          pc_set;
  logic          jump;
  logic          branch;
  logic          branch_taken;
  logic          mem_load;
  logic          mem_store;
  csr_data_t     csr_rdata;
  csr_data_t     mepc;
  logic          m_irq_enable;

  logic [PAT_W-1:0] patterns [NUM_PATTERNS];
  int               error_count;

  csr_file_top i_csr_file_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_id_i          (core_id),
    .cluster_id_i       (cluster_id),
    .boot_addr_i        (boot_addr),
    .csr_access_i       (csr_access),
    .csr_addr_i         (csr_addr),
    .csr_op_i           (csr_op),
    .csr_wdata_i        (csr_wdata),
    .pc_if_i            (pc_if),
    .pc_id_i            (pc_id),
    .csr_save_if_i      (csr_save_if),
    .csr_save_id_i      (csr_save_id),
    .csr_save_cause_i   (csr_save_cause),
    .csr_restore_mret_i (csr_restore_mret),
    .csr_cause_i        (csr_cause),
    .id_valid_i         (id_valid),
    .is_decoding_i      (is_decoding),
    .is_compressed_i    (is_compressed),
    .ld_stall_i         (ld_stall),
    .imiss_i            (imiss),
    .pc_set_i           (pc_set),
    .jump_i             (jump),
    .branch_i           (branch),
    .branch_taken_i     (branch_taken),
    .mem_load_i         (mem_load),
    .mem_store_i        (mem_store),
    .csr_rdata_o        (csr_rdata),
    .mepc_o             (mepc),
    .m_irq_enable_o     (m_irq_enable)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic drive_idle();
    csr_access       = 1'b0;
    csr_addr         = '0;
    csr_op           = CSR_OP_NONE;
    csr_wdata        = '0;
    csr_save_cause   = 1'b0;
    csr_save_if      = 1'b0;
    csr_save_id      = 1'b0;
    csr_restore_mret = 1'b0;
    csr_cause        = '0;
    pc_if            = '0;
    pc_id            = '0;
    {id_valid, is_decoding, is_compressed, ld_stall, imiss, pc_set} = '0;
    {jump, branch, branch_taken, mem_load, mem_store} = '0;
  endtask

  // field layout matches the column header of the data file
  task automatic apply_pattern(input logic [PAT_W-1:0] p);
    csr_access       = p[176];
    csr_addr         = p[175:164];
    csr_op           = csr_op_e'(p[161:160]);
    csr_wdata        = p[159:128];
    csr_save_cause   = p[127];
    csr_save_if      = p[126];
    csr_save_id      = p[125];
    csr_restore_mret = p[124];
    csr_cause        = p[121:116];
    pc_if            = p[115:84];
    pc_id            = p[83:52];
    id_valid         = p[50];
    is_decoding      = p[49];
    is_compressed    = p[48];
    ld_stall         = p[47];
    imiss            = p[46];
    pc_set           = p[45];
    jump             = p[44];
    branch           = p[43];
    branch_taken     = p[42];
    mem_load         = p[41];
    mem_store        = p[40];
  endtask

  task automatic check_outputs(input int idx, input logic [PAT_W-1:0] p);
    // bit 36 clear marks a row whose read data is not checked
    if (p[36] && (csr_rdata !== p[35:4])) begin
      $display("CHECK FAILED t=%0t row %0d csr_rdata_o expected %h got %h",
               $time, idx, p[35:4], csr_rdata);
      error_count++;
    end
    // a mepc read shows the mepc register itself
    if (p[36] && (p[175:164] == ADDR_MEPC) && (mepc !== p[35:4])) begin
      $display("CHECK FAILED t=%0t row %0d mepc_o expected %h got %h",
               $time, idx, p[35:4], mepc);
      error_count++;
    end
    if (m_irq_enable !== p[0]) begin
      $display("CHECK FAILED t=%0t row %0d m_irq_enable_o expected %b got %b",
               $time, idx, p[0], m_irq_enable);
      error_count++;
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    error_count = 0;
    core_id     = 4'h5;
    cluster_id  = 6'h2a;
    boot_addr   = 24'h1c0000;
    rst_n       = 1'b0;
    drive_idle();
    $readmemh("testbench/csr_patterns.txt", patterns);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      @(negedge clk);
      apply_pattern(patterns[i]);
      // outputs settle well before the next rising edge
      #1;
      check_outputs(i, patterns[i]);
    end
    @(negedge clk);
    drive_idle();
    $display("errors: %0d over %0d patterns", error_count, NUM_PATTERNS);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: pattern replay did not finish within %0d ns", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/csr_file_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  csr_pkg::hart_core_t    core_id_i,
  input  csr_pkg::hart_cluster_t cluster_id_i,
  input  csr_pkg::tvec_base_t    boot_addr_i,
  input  logic                   csr_access_i,
  input  csr_pkg::csr_addr_t     csr_addr_i,
  input  csr_pkg::csr_op_e       csr_op_i,
  input  csr_pkg::csr_data_t     csr_wdata_i,
  input  csr_pkg::csr_data_t     pc_if_i,
  input  csr_pkg::csr_data_t     pc_id_i,
  input  logic                   csr_save_if_i,
  input  logic                   csr_save_id_i,
  input  logic                   csr_save_cause_i,
  input  logic                   csr_restore_mret_i,
  input  csr_pkg::cause_t        csr_cause_i,
  input  logic                   id_valid_i,
  input  logic                   is_decoding_i,
  input  logic                   is_compressed_i,
  input  logic                   ld_stall_i,
  input  logic                   imiss_i,
  input  logic                   pc_set_i,
  input  logic                   jump_i,
  input  logic                   branch_i,
  input  logic                   branch_taken_i,
  input  logic                   mem_load_i,
  input  logic                   mem_store_i,
  output csr_pkg::csr_data_t     csr_rdata_o,
  output csr_pkg::csr_data_t     mepc_o,
  output logic                   m_irq_enable_o
);

  import csr_pkg::*;

  // merged write data and strobes
  csr_data_t wdata;
  logic      mstatus_we;
  logic      mepc_we;
  logic      mcause_we;
  logic      pcer_we;
  logic      pcmr_we;
  perf_vec_t pccr_we;

  // register values back to the read mux
  logic                          mstatus_mie;
  logic                          mstatus_mpie;
  cause_t                        mcause;
  perf_vec_t                     pcer;
  logic [PERF_MODE_W-1:0]        pcmr;
  csr_data_t [N_PERF_CNT-1:0]    pccr;

  csr_access_decode i_access (
    .csr_access_i   (csr_access_i),
    .csr_addr_i     (csr_addr_i),
    .csr_op_i       (csr_op_i),
    .csr_wdata_i    (csr_wdata_i),
    .core_id_i      (core_id_i),
    .cluster_id_i   (cluster_id_i),
    .mtvec_base_i   (boot_addr_i),
    .mstatus_mie_i  (mstatus_mie),
    .mstatus_mpie_i (mstatus_mpie),
    .mepc_i         (mepc_o),
    .mcause_i       (mcause),
    .pcer_i         (pcer),
    .pcmr_i         (pcmr),
    .pccr_i         (pccr),
    .csr_rdata_o    (csr_rdata_o),
    .wdata_o        (wdata),
    .mstatus_we_o   (mstatus_we),
    .mepc_we_o      (mepc_we),
    .mcause_we_o    (mcause_we),
    .pcer_we_o      (pcer_we),
    .pcmr_we_o      (pcmr_we),
    .pccr_we_o      (pccr_we)
  );

  trap_csr_regs i_trap (
    .clk                (clk),
    .rst_n              (rst_n),
    .wdata_i            (wdata),
    .mstatus_we_i       (mstatus_we),
    .mepc_we_i          (mepc_we),
    .mcause_we_i        (mcause_we),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_cause_i        (csr_cause_i),
    .mstatus_mie_o      (mstatus_mie),
    .mstatus_mpie_o     (mstatus_mpie),
    .mepc_o             (mepc_o),
    .mcause_o           (mcause),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  perf_cfg_regs i_perf_cfg (
    .clk       (clk),
    .rst_n     (rst_n),
    .wdata_i   (wdata),
    .pcer_we_i (pcer_we),
    .pcmr_we_i (pcmr_we),
    .pcer_o    (pcer),
    .pcmr_o    (pcmr)
  );

  perf_counter_bank i_perf_cnt (
    .clk             (clk),
    .rst_n           (rst_n),
    .pcer_i          (pcer),
    .pcmr_i          (pcmr),
    .pccr_we_i       (pccr_we),
    .wdata_i         (wdata),
    .id_valid_i      (id_valid_i),
    .is_decoding_i   (is_decoding_i),
    .is_compressed_i (is_compressed_i),
    .ld_stall_i      (ld_stall_i),
    .imiss_i         (imiss_i),
    .pc_set_i        (pc_set_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .branch_taken_i  (branch_taken_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .pccr_o          (pccr)
  );

endmodule

`default_nettype wire

//--- design/perf_counter_bank.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counter_bank (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  csr_pkg::perf_vec_t                           pcer_i,
  input  logic [csr_pkg::PERF_MODE_W-1:0]              pcmr_i,
  input  csr_pkg::perf_vec_t                           pccr_we_i,
  input  csr_pkg::csr_data_t                           wdata_i,
  input  logic                                         id_valid_i,
  input  logic                                         is_decoding_i,
  input  logic                                         is_compressed_i,
  input  logic                                         ld_stall_i,
  input  logic                                         imiss_i,
  input  logic                                         pc_set_i,
  input  logic                                         jump_i,
  input  logic                                         branch_i,
  input  logic                                         branch_taken_i,
  input  logic                                         mem_load_i,
  input  logic                                         mem_store_i,
  output csr_pkg::csr_data_t [csr_pkg::N_PERF_CNT-1:0] pccr_o
);

  import csr_pkg::*;

  logic      id_valid_q;
  perf_vec_t evt;
  perf_vec_t inc_d;
  perf_vec_t inc_q;

  ////////////////////////////////////////
  // event sources
  ////////////////////////////////////////

  // stall, jump and branch events use id_valid from the previous cycle
  assign evt[0] = 1'b1;
  assign evt[1] = id_valid_i & is_decoding_i;
  assign evt[2] = ld_stall_i & id_valid_q;
  // fetch wait, redirects excluded
  assign evt[3] = imiss_i & ~pc_set_i;
  assign evt[4] = mem_load_i;
  assign evt[5] = mem_store_i;
  assign evt[6] = jump_i & id_valid_q;
  assign evt[7] = branch_i & id_valid_q;
  assign evt[8] = branch_i & branch_taken_i & id_valid_q;
  assign evt[9] = id_valid_i & is_decoding_i & is_compressed_i;

  // per counter enable and global enable in mode bit 0
  assign inc_d = evt & pcer_i & {N_PERF_CNT{pcmr_i[0]}};

  ////////////////////////////////////////
  // pending increments and counters
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
    end else begin
      id_valid_q <= id_valid_i;
      inc_q      <= inc_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pccr_o <= '0;
    end else begin
      for (int i = 0; i < N_PERF_CNT; i++) begin
        if (pccr_we_i[i]) begin
          // csr write wins over a pending increment
          pccr_o[i] <= wdata_i;
        end else if (inc_q[i] && ((pccr_o[i] != '1) || !pcmr_i[1])) begin
          // mode bit 1 holds a full counter
          pccr_o[i] <= pccr_o[i] + 32'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/perf_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module perf_cfg_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  csr_pkg::csr_data_t              wdata_i,
  input  logic                            pcer_we_i,
  input  logic                            pcmr_we_i,
  output csr_pkg::perf_vec_t              pcer_o,
  output logic [csr_pkg::PERF_MODE_W-1:0] pcmr_o
);

  import csr_pkg::*;

  // event enables, one per counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_o <= '0;
    end else if (pcer_we_i) begin
      pcer_o <= wdata_i[N_PERF_CNT-1:0];
    end
  end

  // counting on and saturating out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcmr_o <= PERF_MODE_RESET;
    end else if (pcmr_we_i) begin
      pcmr_o <= wdata_i[PERF_MODE_W-1:0];
    end
  end

endmodule

`default_nettype wire

//--- design/trap_csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module trap_csr_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_data_t  wdata_i,
  input  logic                mstatus_we_i,
  input  logic                mepc_we_i,
  input  logic                mcause_we_i,
  input  logic                csr_save_cause_i,
  input  logic                csr_save_if_i,
  input  logic                csr_save_id_i,
  input  logic                csr_restore_mret_i,
  input  csr_pkg::csr_data_t  pc_if_i,
  input  csr_pkg::csr_data_t  pc_id_i,
  input  csr_pkg::cause_t     csr_cause_i,
  output logic                mstatus_mie_o,
  output logic                mstatus_mpie_o,
  output csr_pkg::csr_data_t  mepc_o,
  output csr_pkg::cause_t     mcause_o,
  output logic                m_irq_enable_o
);

  import csr_pkg::*;

  logic      mie_d;
  logic      mpie_d;
  csr_data_t mepc_d;
  cause_t    mcause_d;
  csr_data_t exception_pc;

  // pc to save on trap entry
  always_comb begin
    if (csr_save_if_i) begin
      exception_pc = pc_if_i;
    end else if (csr_save_id_i) begin
      exception_pc = pc_id_i;
    end else begin
      // id stage pc is also the fallback
      exception_pc = pc_id_i;
    end
  end

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    mie_d    = mstatus_mie_o;
    mpie_d   = mstatus_mpie_o;
    mepc_d   = mepc_o;
    mcause_d = mcause_o;

    // plain csr writes first
    if (mstatus_we_i) begin
      mie_d  = wdata_i[MSTATUS_MIE_BIT];
      mpie_d = wdata_i[MSTATUS_MPIE_BIT];
    end
    if (mepc_we_i) begin
      mepc_d = wdata_i;
    end
    if (mcause_we_i) begin
      // interrupt flag lives at bit 31 in the csr view
      mcause_d = {wdata_i[31], wdata_i[4:0]};
    end

    // controller strobes override, save beats mret
    if (csr_save_cause_i) begin
      mpie_d   = mstatus_mie_o;
      mie_d    = 1'b0;
      mepc_d   = exception_pc;
      mcause_d = csr_cause_i;
    end else if (csr_restore_mret_i) begin
      mie_d  = mstatus_mpie_o;
      mpie_d = 1'b1;
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_mie_o  <= 1'b0;
      mstatus_mpie_o <= 1'b0;
      mepc_o         <= '0;
      mcause_o       <= '0;
    end else begin
      mstatus_mie_o  <= mie_d;
      mstatus_mpie_o <= mpie_d;
      mepc_o         <= mepc_d;
      mcause_o       <= mcause_d;
    end
  end

  // machine mode only, so mie alone gates interrupts
  assign m_irq_enable_o = mstatus_mie_o;

endmodule

`default_nettype wire

//--- design/csr_access_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access_decode (
  input  logic                                 csr_access_i,
  input  csr_pkg::csr_addr_t                   csr_addr_i,
  input  csr_pkg::csr_op_e                     csr_op_i,
  input  csr_pkg::csr_data_t                   csr_wdata_i,
  input  csr_pkg::hart_core_t                  core_id_i,
  input  csr_pkg::hart_cluster_t               cluster_id_i,
  input  csr_pkg::tvec_base_t                  mtvec_base_i,
  input  logic                                 mstatus_mie_i,
  input  logic                                 mstatus_mpie_i,
  input  csr_pkg::csr_data_t                   mepc_i,
  input  csr_pkg::cause_t                      mcause_i,
  input  csr_pkg::perf_vec_t                   pcer_i,
  input  logic [csr_pkg::PERF_MODE_W-1:0]      pcmr_i,
  input  csr_pkg::csr_data_t [csr_pkg::N_PERF_CNT-1:0] pccr_i,
  output csr_pkg::csr_data_t                   csr_rdata_o,
  output csr_pkg::csr_data_t                   wdata_o,
  output logic                                 mstatus_we_o,
  output logic                                 mepc_we_o,
  output logic                                 mcause_we_o,
  output logic                                 pcer_we_o,
  output logic                                 pcmr_we_o,
  output csr_pkg::perf_vec_t                   pccr_we_o
);

  import csr_pkg::*;

  logic       csr_we;
  logic       is_pccr;
  logic [4:0] pccr_idx;

  // 0x780 to 0x79F window
  assign is_pccr  = (csr_addr_i[11:5] == ADDR_PCCR_BASE[11:5]);
  assign pccr_idx = csr_addr_i[4:0];

  ////////////////////////////////////////
  // read mux
  ////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      ADDR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]        = mstatus_mie_i;
        csr_rdata_o[MSTATUS_MPIE_BIT]       = mstatus_mpie_i;
        // mpp stuck at machine mode
        csr_rdata_o[MSTATUS_MPP_LSB +: 2]   = 2'b11;
      end
      ADDR_MTVEC:   csr_rdata_o = {mtvec_base_i, 6'b0, MTVEC_MODE};
      ADDR_MEPC:    csr_rdata_o = mepc_i;
      ADDR_MCAUSE:  csr_rdata_o = {mcause_i[5], 26'b0, mcause_i[4:0]};
      ADDR_MHARTID: csr_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      ADDR_PCER:    csr_rdata_o[N_PERF_CNT-1:0] = pcer_i;
      ADDR_PCMR:    csr_rdata_o[PERF_MODE_W-1:0] = pcmr_i;
      default: begin
        // unimplemented counters and the write-all slot read zero
        if (is_pccr && (pccr_idx < 5'(N_PERF_CNT))) begin
          csr_rdata_o = pccr_i[pccr_idx];
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // operation merge and write strobes
  ////////////////////////////////////////

  always_comb begin
    wdata_o = csr_wdata_i;
    case (csr_op_i)
      CSR_OP_NONE,
      CSR_OP_WRITE: wdata_o = csr_wdata_i;
      CSR_OP_SET:   wdata_o = csr_rdata_o | csr_wdata_i;
      CSR_OP_CLEAR: wdata_o = csr_rdata_o & ~csr_wdata_i;
      default:      wdata_o = csr_wdata_i;
    endcase
  end

  assign csr_we = csr_access_i && (csr_op_i != CSR_OP_NONE);

  // mtvec and mhartid are read only
  assign mstatus_we_o = csr_we && (csr_addr_i == ADDR_MSTATUS);
  assign mepc_we_o    = csr_we && (csr_addr_i == ADDR_MEPC);
  assign mcause_we_o  = csr_we && (csr_addr_i == ADDR_MCAUSE);
  assign pcer_we_o    = csr_we && (csr_addr_i == ADDR_PCER);
  assign pcmr_we_o    = csr_we && (csr_addr_i == ADDR_PCMR);

  always_comb begin
    for (int i = 0; i < N_PERF_CNT; i++) begin
      pccr_we_o[i] = csr_we && ((csr_addr_i == ADDR_PCCR_ALL) ||
                                (is_pccr && (pccr_idx == 5'(i))));
    end
  end

endmodule

`default_nettype wire

//--- design/csr_pkg.sv
`default_nettype none

package csr_pkg;

  // data and address words
  typedef logic [31:0] csr_data_t;
  typedef logic [11:0] csr_addr_t;

  // top bit set means interrupt
  typedef logic [5:0] cause_t;

  typedef logic [23:0] tvec_base_t;
  typedef logic [3:0]  hart_core_t;
  typedef logic [5:0]  hart_cluster_t;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // performance counters
  localparam int N_PERF_CNT = 10;
  typedef logic [N_PERF_CNT-1:0] perf_vec_t;

  // bit 0 global enable, bit 1 saturation
  localparam int PERF_MODE_W = 2;
  localparam logic [PERF_MODE_W-1:0] PERF_MODE_RESET = 2'd3;

  // machine mode address map
  localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
  localparam csr_addr_t ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t ADDR_MEPC      = 12'h341;
  localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
  localparam csr_addr_t ADDR_PCCR_BASE = 12'h780;
  localparam csr_addr_t ADDR_PCCR_ALL  = 12'h79F;
  localparam csr_addr_t ADDR_PCER      = 12'h7A0;
  localparam csr_addr_t ADDR_PCMR      = 12'h7A1;

  // field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam logic [1:0] MTVEC_MODE = 2'd1;

endpackage

`default_nettype wire
